//--- design/cache_write_pkg.sv
package cache_write_pkg;

    // byte address and word geometry
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    localparam int BE_DATA_W   = 64;               // memory side beat width

    localparam int NBYTES      = DATA_W / 8;       // 4
    localparam int BE_NBYTES   = BE_DATA_W / 8;    // 8
    localparam int NBYTES_W    = $clog2(NBYTES);   // 2
    localparam int BE_NBYTES_W = $clog2(BE_NBYTES); // 3

    localparam int WORD_ADDR_W = ADDR_W - NBYTES_W; // word address bits, 14

    // cache words carried by one memory beat
    localparam int WORDS_PER_BEAT = BE_DATA_W / DATA_W;
    localparam int WORD_SEL_W     = BE_NBYTES_W - NBYTES_W;

    // one word write from the core
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] addr;   // word address
        logic [DATA_W-1:0]      wdata;
        logic [NBYTES-1:0]      wstrb;
    } wr_req_t;

    // one AXI write data beat, wlast is implied
    typedef struct packed {
        logic [BE_DATA_W-1:0] wdata;
        logic [BE_NBYTES-1:0] wstrb;
    } axi_w_t;

    // write response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- design/write_buffer.sv
`timescale 1ns/1ps

module write_buffer import cache_write_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  logic    clk,
    input  logic    reset,

    // four-phase link from the core
    input  logic    req,
    input  wr_req_t req_data,
    output logic    ack,

    // head entry toward the write channel
    output wr_req_t head,
    output logic    head_valid,
    input  logic    entry_done,

    output logic    empty
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(BUF_DEPTH);

    wr_req_t          mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic full;
    logic push;
    logic pop;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);

    // one push per req level, only while ack is still low
    assign push = req & ~ack & ~full;
    assign pop  = entry_done;

    // acknowledge state of the handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (push) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;                // core released req
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1); // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

    // occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    // channel looks at the head without consuming it
    assign head       = mem[rd_ptr];
    assign head_valid = ~empty;

endmodule

//--- design/write_channel_axi.sv
`timescale 1ns/1ps

module write_channel_axi import cache_write_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // head entry of the write buffer
    input  wr_req_t           head,
    input  logic              head_valid,
    output logic              entry_done,
    output logic              idle,

    // AXI write address
    output logic              axi_awvalid,
    output logic [ADDR_W-1:0] axi_awaddr,
    input  logic              axi_awready,

    // AXI write data
    output logic              axi_wvalid,
    output axi_w_t            axi_w,
    input  logic              axi_wready,

    // AXI write response
    input  logic              axi_bvalid,
    input  logic [1:0]        axi_bresp,
    output logic              axi_bready
);

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_address = 2'd1,
        st_write   = 2'd2,
        st_verif   = 2'd3
    } state_t;

    state_t state;
    state_t state_next;

    logic                     resp_okay;
    logic [WORD_SEL_W-1:0]    word_sel;
    logic [BE_NBYTES-1:0]     wstrb_ext;

    // beat alignment
    // the word lands in every lane, the strobes pick the lane
    assign word_sel  = head.addr[WORD_SEL_W-1:0];
    assign wstrb_ext = {{(BE_NBYTES-NBYTES){1'b0}}, head.wstrb};

    assign axi_awaddr  = {head.addr[WORD_ADDR_W-1:WORD_SEL_W], {BE_NBYTES_W{1'b0}}};
    assign axi_w.wdata = {WORDS_PER_BEAT{head.wdata}};
    assign axi_w.wstrb = wstrb_ext << {word_sel, {NBYTES_W{1'b0}}}; // lane * NBYTES

    assign resp_okay = (axi_bresp == RESP_OKAY);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (head_valid) begin
                    state_next = st_address;
                end
            end
            st_address: begin
                if (axi_awready) begin
                    state_next = st_write;
                end
            end
            st_write: begin
                if (axi_wready) begin
                    state_next = st_verif;
                end
            end
            st_verif: begin
                if (axi_bvalid) begin
                    if (resp_okay) begin
                        state_next = st_idle;    // entry retired
                    end else begin
                        state_next = st_address; // error, same entry again
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // handshake outputs follow the state
    assign axi_awvalid = (state == st_address);
    assign axi_wvalid  = (state == st_write);
    assign axi_bready  = (state == st_verif);
    assign idle        = (state == st_idle);

    // pop the head only on a clean response
    assign entry_done  = (state == st_verif) & axi_bvalid & resp_okay;

endmodule

//--- design/cache_write_path.sv
`timescale 1ns/1ps

module cache_write_path import cache_write_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,

    // core side, four-phase
    input  logic              req,
    output logic              ack,
    input  wr_req_t           req_data,
    output logic              drained,

    // AXI memory side
    output logic              axi_awvalid,
    output logic [ADDR_W-1:0] axi_awaddr,
    input  logic              axi_awready,
    output logic              axi_wvalid,
    output axi_w_t            axi_w,
    input  logic              axi_wready,
    input  logic              axi_bvalid,
    input  logic [1:0]        axi_bresp,
    output logic              axi_bready
);

    wr_req_t head;
    logic    head_valid;
    logic    entry_done;
    logic    empty;
    logic    idle;

    write_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) write_buffer_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .head       (head),
        .head_valid (head_valid),
        .entry_done (entry_done),
        .empty      (empty)
    );

    write_channel_axi write_channel_axi_inst (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .head_valid  (head_valid),
        .entry_done  (entry_done),
        .idle        (idle),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awready (axi_awready),
        .axi_wvalid  (axi_wvalid),
        .axi_w       (axi_w),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .axi_bready  (axi_bready)
    );

    // nothing queued and no write in flight
    assign drained = empty & idle;

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;                   // released on a falling edge
    end

endmodule

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import cache_write_pkg::*; #(
    parameter int SEED       = 1,
    parameter int ERR_PERIOD = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              aw_stall,     // holds awready low
    input  logic              axi_awvalid,
    input  logic [ADDR_W-1:0] axi_awaddr,
    output logic              axi_awready,
    input  logic              axi_wvalid,
    input  axi_w_t            axi_w,
    output logic              axi_wready,
    output logic              axi_bvalid,
    output logic [1:0]        axi_bresp,
    input  logic              axi_bready,
    output int                err_count
);

    logic [7:0]        mem [1 << ADDR_W];
    logic [ADDR_W-1:0] wr_addr;
    logic [1:0]        resp_code;
    logic              resp_pending;
    logic              b_taken;
    logic              stall_q;
    int                attempts;

    always @(posedge clk) begin
        stall_q <= aw_stall;
    end

    // readies and response move on the falling edge only
    initial begin
        void'($urandom(SEED));
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;    // every address bit counts
        end
        axi_awready  = 1'b0;
        axi_wready   = 1'b0;
        axi_bvalid   = 1'b0;
        axi_bresp    = RESP_OKAY;
        resp_code    = RESP_OKAY;
        resp_pending = 1'b0;
        b_taken      = 1'b0;
        wr_addr      = '0;
        attempts     = 0;
        err_count    = 0;
        forever begin
            @(negedge clk or posedge reset);
            if (!reset) begin
                if (b_taken) begin
                    axi_bvalid = 1'b0;          // taken on the last rising edge
                    b_taken    = 1'b0;
                end
                axi_awready = 1'b0;
                axi_wready  = 1'b0;
                if (axi_awvalid && !stall_q && $urandom_range(2) != 0) begin
                    axi_awready = 1'b1;
                    wr_addr     = axi_awaddr;
                end
                if (resp_pending && $urandom_range(2) != 0) begin
                    axi_bvalid   = 1'b1;
                    axi_bresp    = resp_code;
                    resp_pending = 1'b0;
                end else if (axi_wvalid && $urandom_range(2) != 0) begin
                    axi_wready = 1'b1;
                    attempts++;
                    if (attempts % ERR_PERIOD == 0) begin
                        resp_code = RESP_SLVERR;    // nothing written
                        err_count++;
                    end else begin
                        resp_code = RESP_OKAY;
                        for (int b = 0; b < BE_NBYTES; b++) begin
                            if (axi_w.wstrb[b]) begin
                                mem[wr_addr + ADDR_W'(b)] = axi_w.wdata[8*b +: 8];
                            end
                        end
                    end
                    resp_pending = 1'b1;
                end
                b_taken = axi_bvalid && axi_bready;
            end
        end
    end

endmodule

//--- dv/cache_write_path_tb.sv
`timescale 1ns/1ps

module cache_write_path_tb import cache_write_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int BUF_DEPTH    = 4;
    localparam int NUM_ROWS     = 10;
    localparam int FREE_ROWS    = NUM_ROWS - BUF_DEPTH - 2;  // rows before the aw stall
    localparam int STALL_CYCLES = 12;
    localparam int ERR_PERIOD   = 3;
    localparam int SEED         = 46;

    // word address, data, strobes
    wr_req_t rows [NUM_ROWS] = '{
        {14'h0010, 32'h1122_3344, 4'b1111},
        {14'h0011, 32'h5566_7788, 4'b1111},
        {14'h0010, 32'haabb_ccdd, 4'b0101},
        {14'h1ffe, 32'h0bad_f00d, 4'b1100},
        {14'h0123, 32'hcafe_babe, 4'b0011},
        {14'h0123, 32'h0000_00ff, 4'b1000},
        {14'h3fff, 32'h8765_4321, 4'b1111},
        {14'h0000, 32'h1357_9bdf, 4'b0001},
        {14'h0042, 32'h2468_ace0, 4'b1110},
        {14'h0043, 32'hf0f0_0f0f, 4'b0110}
    };

    logic              clk;
    logic              reset;
    logic              req;
    logic              ack;
    wr_req_t           req_data;
    logic              drained;
    logic              aw_stall;
    logic              axi_awvalid;
    logic [ADDR_W-1:0] axi_awaddr;
    logic              axi_awready;
    logic              axi_wvalid;
    axi_w_t            axi_w;
    logic              axi_wready;
    logic              axi_bvalid;
    logic [1:0]        axi_bresp;
    logic              axi_bready;
    int                model_errs;

    logic [ADDR_W-1:0] last_awaddr;
    logic [7:0]        ref_mem [1 << ADDR_W];
    int                aw_count = 0;
    int                attempts = 0;
    int                retired = 0;
    int                resp_errs = 0;
    int                error_count = 0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    cache_write_path #(.BUF_DEPTH(BUF_DEPTH)) cache_write_path_inst (.*);

    axi_mem_model #(.SEED(SEED), .ERR_PERIOD(ERR_PERIOD)) axi_mem_model_inst (
        .*,
        .err_count (model_errs)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // beat rule, written out from the bus view
    function automatic logic [15:0] beat_addr(input wr_req_t r);
        return {r.addr[13:1], 3'b000};
    endfunction

    function automatic logic [7:0] beat_strb(input wr_req_t r);
        return r.addr[0] ? {r.wstrb, 4'b0000} : {4'b0000, r.wstrb};
    endfunction

    task automatic send_row(input int idx);
        req_data = rows[idx];
        req      = 1'b1;
        do @(negedge clk); while (!ack);
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    // buffer is full here, ack must wait for a retirement
    task automatic send_blocked_row(input int idx);
        int retired_before;
        retired_before = retired;
        req_data       = rows[idx];
        req            = 1'b1;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_value("ack", 64'(ack), 64'd0);
        end
        aw_stall = 1'b0;
        do @(negedge clk); while (!ack);
        check_value("retired before ack", 64'(retired > retired_before), 64'd1);
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (!drained);
    endtask

    // scoreboard, every attempt belongs to the oldest unretired row
    always @(posedge clk) begin
        logic [1:0] exp_resp;
        if (axi_awvalid && axi_awready) begin
            aw_count++;
            last_awaddr = axi_awaddr;
        end
        if (axi_wvalid && axi_wready) begin
            attempts++;
            check_value("row index", 64'(retired < NUM_ROWS), 64'd1);
            check_value("axi_awaddr", 64'(last_awaddr), 64'(beat_addr(rows[retired])));
            check_value("axi_w.wdata", 64'(axi_w.wdata),
                        {rows[retired].wdata, rows[retired].wdata});
            check_value("axi_w.wstrb", 64'(axi_w.wstrb), 64'(beat_strb(rows[retired])));
        end
        if (axi_bvalid && axi_bready) begin
            exp_resp = (attempts % ERR_PERIOD == 0) ? RESP_SLVERR : RESP_OKAY;
            check_value("axi_bresp", 64'(axi_bresp), 64'(exp_resp));
            if (axi_bresp == RESP_OKAY) begin
                retired++;
            end else begin
                resp_errs++;
            end
        end
    end

    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("run timed out before the DUT drained all rows");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        req      = 1'b0;
        req_data = '0;
        aw_stall = 1'b0;
        @(negedge reset);
        @(negedge clk);
        check_value("ack", 64'(ack), 64'd0);
        check_value("axi_awvalid", 64'(axi_awvalid), 64'd0);
        check_value("axi_wvalid", 64'(axi_wvalid), 64'd0);
        check_value("axi_bready", 64'(axi_bready), 64'd0);
        check_value("drained", 64'(drained), 64'd1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == FREE_ROWS) begin
                wait_drained();
                aw_stall = 1'b1;            // queue fills behind the head
            end
            if (i == FREE_ROWS + BUF_DEPTH) begin
                send_blocked_row(i);
            end else begin
                send_row(i);
            end
        end
        wait_drained();

        check_value("retired rows", 64'(retired), 64'(NUM_ROWS));
        check_value("aw handshakes", 64'(aw_count), 64'(NUM_ROWS + model_errs));
        check_value("error responses", 64'(resp_errs), 64'(model_errs));

        // reference image, rows merged in table order
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (rows[i].wstrb[b]) begin
                    ref_mem[{rows[i].addr, 2'b00} + 16'(b)] = rows[i].wdata[8*b +: 8];
                end
            end
        end
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            check_value($sformatf("mem[%h]", a), 64'(axi_mem_model_inst.mem[a]),
                        64'(ref_mem[a]));
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

//--- sources.f
design/cache_write_pkg.sv
design/write_buffer.sv
design/write_channel_axi.sv
design/cache_write_path.sv
dv/clock_gen.sv
dv/axi_mem_model.sv
dv/cache_write_path_tb.sv

//--- Makefile
TOP = cache_write_path_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module cache_write_path \
		design/cache_write_pkg.sv design/write_buffer.sv \
		design/write_channel_axi.sv design/cache_write_path.sv

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
